// ==== logic/opll_reg_pkg.sv ====
package opll_reg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes and register map
    ////////////////////////////////////////////////////////////////////////////

    // channel count and operator slots per scan
    localparam int NUM_CH    = 9;
    localparam int NUM_SLOTS = 18;

    // custom patch occupies 0x00 up to this register
    localparam logic [7:0] ADDR_PATCH_LAST = 8'h07;

    // per-channel banks, low nibble is the channel
    localparam logic [7:0] ADDR_FNUM_LO  = 8'h10;
    localparam logic [7:0] ADDR_FNUM_HI  = 8'h20;
    localparam logic [7:0] ADDR_INST_VOL = 8'h30;

    ////////////////////////////////////////////////////////////////////////////
    // bus write
    ////////////////////////////////////////////////////////////////////////////

    // one register write, addr is the latched register number
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } reg_wr_t;

    // custom patch byte, meaning depends on register number
    // 0x00/0x01
    typedef struct packed {
        logic       am;
        logic       pm;
        logic       etyp;
        logic       ksr;
        logic [3:0] mul;
    } patch_mult_t;

    // 0x02, modulator only
    typedef struct packed {
        logic [1:0] ksl;
        logic [5:0] tl;
    } patch_level_t;

    // 0x03, carrier ksl shares the byte with feedback
    typedef struct packed {
        logic [1:0] ksl;
        logic       spare;
        logic       dc;
        logic       dm;
        logic [2:0] fb;
    } patch_fb_t;

    // 0x04-0x07, ar/dr or sl/rr
    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } patch_rate_t;

    typedef union packed {
        patch_mult_t  mult;
        patch_level_t level;
        patch_fb_t    fbk;
        patch_rate_t  rate;
    } patch_byte_u;

    ////////////////////////////////////////////////////////////////////////////
    // patch, channel and slot output
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       am;
        logic       pm;
        logic       etyp;
        logic       ksr;
        logic [3:0] mul;
        logic [1:0] ksl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
    } op_patch_t;

    // full instrument, rom rows decode to the same layout
    typedef struct packed {
        op_patch_t  mod;
        op_patch_t  car;
        logic [5:0] tl;
        logic       dc;
        logic       dm;
        logic [2:0] fb;
    } patch_t;

    typedef struct packed {
        logic [8:0] fnum;
        logic [2:0] block;
        logic       kon;
        logic       susen;
        logic [3:0] vol;
        logic [3:0] inst;
    } chan_t;

    typedef struct packed {
        logic [8:0] fnum;
        logic [2:0] block;
        logic       kon;
        logic       susen;
        logic [5:0] tl;
        logic       dc;
        logic       dm;
        logic [2:0] fb;
        logic       am;
        logic       pm;
        logic       etyp;
        logic       ksr;
        logic [3:0] mul;
        logic [1:0] ksl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
    } op_param_t;

endpackage

// ==== logic/opll_patch_rom.sv ====
`timescale 1ns/1ps

module opll_patch_rom (
    input  logic                 i_EMUCLK,
    input  logic                 i_RST_n,
    input  logic [3:0]           i_inst,
    output opll_reg_pkg::patch_t o_patch
);

// rows in chip column order
// tl dc dm fb, then per field the modulator bits above the carrier bits
logic [62:0] row;

// pull one operator half out of a row, car selects the lower bits
function automatic opll_reg_pkg::op_patch_t unpack_op(input logic [62:0] r, input logic car);
    opll_reg_pkg::op_patch_t op;
    op.am   = r[51 - car];
    op.pm   = r[49 - car];
    op.etyp = r[47 - car];
    op.ksr  = r[45 - car];
    op.mul  = r[43 - 4*car -: 4];
    op.ksl  = r[35 - 2*car -: 2];
    op.ar   = r[31 - 4*car -: 4];
    op.dr   = r[23 - 4*car -: 4];
    op.sl   = r[15 - 4*car -: 4];
    op.rr   = r[7 - 4*car -: 4];
    return op;
endfunction

always_comb begin
    case (i_inst)
        4'h1: row = 63'b011110_1_0_111_00_11_11_10_00010001_0000_11010111_00001000_00000001_00000111;
        4'h2: row = 63'b011010_0_1_101_00_01_00_10_00110001_0000_11011111_10000111_00100001_00110011;
        4'h3: row = 63'b011001_0_0_000_00_00_00_10_00110001_1000_11111100_00100100_00010010_00010011;
        4'h4: row = 63'b001110_0_0_111_00_01_11_10_00010001_0000_10100110_10000100_01110010_00000111;
        4'h5: row = 63'b011110_0_0_110_00_00_11_10_00100001_0000_11100111_00000110_00000010_00001000;
        4'h6: row = 63'b010110_0_0_101_00_00_11_10_00010010_0000_11100111_00000001_00000001_00001000;
        4'h7: row = 63'b011101_0_0_111_00_01_11_00_00010001_0000_10001000_00100001_00010000_00000111;
        4'h8: row = 63'b101101_1_0_100_00_00_11_00_00110001_0000_10100111_00100010_00000000_00000111;
        4'h9: row = 63'b011011_0_0_110_00_11_11_00_00010001_0000_01100110_01000101_00010001_00000111;
        4'hA: row = 63'b001011_1_1_000_00_11_01_00_00010001_0000_10001111_01010111_01110000_00010111;
        4'hB: row = 63'b000011_1_0_001_00_00_00_10_00110001_1000_11111110_10100100_00010000_00000100;
        4'hC: row = 63'b100100_0_0_111_01_01_00_10_01110001_0000_11111111_10001000_00100001_00100010;
        4'hD: row = 63'b001100_0_0_101_00_11_10_01_00010000_0000_11001111_00100101_00100100_00000010;
        4'hE: row = 63'b010101_0_0_011_00_00_00_00_00010001_0100_11001001_10010101_00000000_00110010;
        4'hF: row = 63'b001001_0_0_011_00_11_10_00_00010001_1000_11111110_00010100_01000001_00000011;
        // entry 0 is the custom patch slot, empty here
        default: row = '0;
    endcase
end

// registered output, one clock behind i_inst
always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        o_patch <= '0;
    end else begin
        o_patch <= '{mod: unpack_op(row, 1'b0),
                     car: unpack_op(row, 1'b1),
                     tl:  row[62:57],
                     dc:  row[56],
                     dm:  row[55],
                     fb:  row[54:52]};
    end
end

endmodule

// ==== logic/opll_bus_writer.sv ====
`timescale 1ns/1ps

module opll_bus_writer (
    input  logic                  i_EMUCLK,
    input  logic                  i_RST_n,
    input  logic                  i_CS_n,
    input  logic                  i_WR_n,
    input  logic                  i_A0,
    input  logic [7:0]            i_D,
    input  logic                  i_wr_ack,
    output logic                  o_wr_req,
    output opll_reg_pkg::reg_wr_t o_wr
);

////////////////////////////////////////////////////////////////////////////
// bus synchronizer
////////////////////////////////////////////////////////////////////////////

logic [1:0]      cs_n_sync;
logic [1:0]      wr_n_sync;
logic [1:0]      a0_sync;
logic [1:0][7:0] d_sync;

// strobe active when cs and wr both low
logic            strobe;
logic            strobe_q;

// one-clock pulse per write, with its a0 and data
logic            stb;
logic            stb_a0;
logic [7:0]      stb_data;

logic [7:0]      addr_q;
logic            busy;
logic            start;

assign strobe = ~cs_n_sync[1] & ~wr_n_sync[1];

// control lines, idle high out of reset
always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        cs_n_sync <= 2'b11;
        wr_n_sync <= 2'b11;
        strobe_q  <= 1'b0;
        stb       <= 1'b0;
    end else begin
        cs_n_sync <= {cs_n_sync[0], i_CS_n};
        wr_n_sync <= {wr_n_sync[0], i_WR_n};
        strobe_q  <= strobe;
        // leading edge of the strobe
        stb       <= strobe & ~strobe_q;
    end
end

// a0 and data ride alongside, stable while the strobe is held
always_ff @(posedge i_EMUCLK) begin
    a0_sync  <= {a0_sync[0], i_A0};
    d_sync   <= {d_sync[0], i_D};
    stb_a0   <= a0_sync[1];
    stb_data <= d_sync[1];
end

////////////////////////////////////////////////////////////////////////////
// address latch and write requester
////////////////////////////////////////////////////////////////////////////

// handshake busy until ack is back low
assign busy  = o_wr_req | i_wr_ack;
// data write, dropped while busy
assign start = stb & stb_a0 & ~busy;

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        addr_q   <= 8'h00;
        o_wr_req <= 1'b0;
    end else begin
        // a0 low only latches the register number
        if (stb && !stb_a0) begin
            addr_q <= stb_data;
        end
        if (start) begin
            o_wr_req <= 1'b1;
        end else if (i_wr_ack) begin
            // ack seen, release req
            o_wr_req <= 1'b0;
        end
    end
end

// held until the next accepted write
always_ff @(posedge i_EMUCLK) begin
    if (start) begin
        o_wr <= '{addr: addr_q, data: stb_data};
    end
end

endmodule

// ==== logic/opll_reg_file.sv ====
`timescale 1ns/1ps

module opll_reg_file (
    input  logic                  i_EMUCLK,
    input  logic                  i_RST_n,
    input  logic                  i_wr_req,
    input  opll_reg_pkg::reg_wr_t i_wr,
    input  logic [3:0]            i_rd_ch,
    output logic                  o_wr_ack,
    output opll_reg_pkg::chan_t   o_rd_chan,
    output opll_reg_pkg::patch_t  o_patch
);

////////////////////////////////////////////////////////////////////////////
// storage and decode
////////////////////////////////////////////////////////////////////////////

opll_reg_pkg::chan_t       chan_q [0:opll_reg_pkg::NUM_CH-1];
opll_reg_pkg::patch_t      patch_q;

opll_reg_pkg::patch_byte_u pb;
logic [7:0]                base;
logic [3:0]                ch;
logic                      ch_ok;
logic                      take;

// mult byte into one operator half
function automatic opll_reg_pkg::op_patch_t with_mult(
    input opll_reg_pkg::op_patch_t   op,
    input opll_reg_pkg::patch_byte_u b
);
    opll_reg_pkg::op_patch_t r;
    r      = op;
    r.am   = b.mult.am;
    r.pm   = b.mult.pm;
    r.etyp = b.mult.etyp;
    r.ksr  = b.mult.ksr;
    r.mul  = b.mult.mul;
    return r;
endfunction

assign pb    = i_wr.data;
// bank base and channel nibble
assign base  = {i_wr.addr[7:4], 4'h0};
assign ch    = i_wr.addr[3:0];
assign ch_ok = ch < opll_reg_pkg::NUM_CH;
// first clock of a request
assign take  = i_wr_req & ~o_wr_ack;

// acknowledger side
always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        o_wr_ack <= 1'b0;
    end else if (take) begin
        o_wr_ack <= 1'b1;
    end else if (!i_wr_req) begin
        o_wr_ack <= 1'b0;
    end
end

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        patch_q <= '0;
        for (int i = 0; i < opll_reg_pkg::NUM_CH; i++) begin
            chan_q[i] <= '0;
        end
    end else if (take) begin
        if (i_wr.addr <= opll_reg_pkg::ADDR_PATCH_LAST) begin
            // custom patch, even regs modulator, odd regs carrier
            case (i_wr.addr[2:0])
                3'd0: patch_q.mod <= with_mult(patch_q.mod, pb);
                3'd1: patch_q.car <= with_mult(patch_q.car, pb);
                3'd2: begin
                    patch_q.mod.ksl <= pb.level.ksl;
                    patch_q.tl      <= pb.level.tl;
                end
                3'd3: begin
                    patch_q.car.ksl <= pb.fbk.ksl;
                    patch_q.dc      <= pb.fbk.dc;
                    patch_q.dm      <= pb.fbk.dm;
                    patch_q.fb      <= pb.fbk.fb;
                end
                3'd4: begin
                    patch_q.mod.ar <= pb.rate.hi;
                    patch_q.mod.dr <= pb.rate.lo;
                end
                3'd5: begin
                    patch_q.car.ar <= pb.rate.hi;
                    patch_q.car.dr <= pb.rate.lo;
                end
                3'd6: begin
                    patch_q.mod.sl <= pb.rate.hi;
                    patch_q.mod.rr <= pb.rate.lo;
                end
                default: begin
                    patch_q.car.sl <= pb.rate.hi;
                    patch_q.car.rr <= pb.rate.lo;
                end
            endcase
        end else if (ch_ok) begin
            // 0x08-0x0f fall to default and change nothing
            case (base)
                opll_reg_pkg::ADDR_FNUM_LO: chan_q[ch].fnum[7:0] <= i_wr.data;
                opll_reg_pkg::ADDR_FNUM_HI: begin
                    chan_q[ch].susen   <= i_wr.data[5];
                    chan_q[ch].kon     <= i_wr.data[4];
                    chan_q[ch].block   <= i_wr.data[3:1];
                    chan_q[ch].fnum[8] <= i_wr.data[0];
                end
                opll_reg_pkg::ADDR_INST_VOL: begin
                    chan_q[ch].inst <= i_wr.data[7:4];
                    chan_q[ch].vol  <= i_wr.data[3:0];
                end
                default: ;
            endcase
        end
    end
end

// read port for the slot reader
assign o_rd_chan = (i_rd_ch < opll_reg_pkg::NUM_CH) ? chan_q[i_rd_ch] : '0;
assign o_patch   = patch_q;

endmodule

// ==== logic/opll_slot_reader.sv ====
`timescale 1ns/1ps

module opll_slot_reader (
    input  logic                    i_EMUCLK,
    input  logic                    i_RST_n,
    input  opll_reg_pkg::chan_t     i_rd_chan,
    input  opll_reg_pkg::patch_t    i_patch,
    output logic [3:0]              o_rd_ch,
    output logic [4:0]              o_SLOT,
    output opll_reg_pkg::op_param_t o_PARAM
);

////////////////////////////////////////////////////////////////////////////
// stage 0, slot counter and channel/rom address
////////////////////////////////////////////////////////////////////////////

logic [4:0]                slot_q;
logic [4:0]                slot_d1;
opll_reg_pkg::chan_t       chan_d1;
opll_reg_pkg::patch_t      rom_patch;
opll_reg_pkg::patch_t      src;
opll_reg_pkg::op_patch_t   op;
opll_reg_pkg::op_param_t   param;
logic                      is_mod;
logic                      eg_off;

// 0..17 every clock
always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        slot_q <= 5'd0;
    end else if (slot_q == 5'(opll_reg_pkg::NUM_SLOTS - 1)) begin
        slot_q <= 5'd0;
    end else begin
        slot_q <= slot_q + 5'd1;
    end
end

// two slots per channel
assign o_rd_ch = slot_q[4:1];

opll_patch_rom u_rom (
    .i_EMUCLK (i_EMUCLK),
    .i_RST_n  (i_RST_n),
    .i_inst   (i_rd_chan.inst),
    .o_patch  (rom_patch)
);

////////////////////////////////////////////////////////////////////////////
// stage 1, aligned with the rom output
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        slot_d1 <= 5'd0;
        chan_d1 <= '0;
    end else begin
        slot_d1 <= slot_q;
        chan_d1 <= i_rd_chan;
    end
end

// even slot is the modulator
assign is_mod = ~slot_d1[0];
// inst 0 selects the custom patch
assign src    = (chan_d1.inst == 4'h0) ? i_patch : rom_patch;
assign op     = is_mod ? src.mod : src.car;
// silent modulator holds its envelope
assign eg_off = is_mod & ~chan_d1.kon;

always_comb begin
    param.fnum  = chan_d1.fnum;
    param.block = chan_d1.block;
    param.kon   = chan_d1.kon;
    param.susen = chan_d1.susen;
    // carrier level comes from channel volume
    param.tl    = is_mod ? src.tl : {chan_d1.vol, 2'b00};
    param.dc    = src.dc;
    param.dm    = src.dm;
    param.fb    = src.fb;
    param.am    = op.am;
    param.pm    = op.pm;
    param.etyp  = op.etyp;
    param.ksr   = op.ksr;
    param.mul   = op.mul;
    param.ksl   = op.ksl;
    param.ar    = eg_off ? 4'd0 : op.ar;
    param.dr    = eg_off ? 4'd0 : op.dr;
    param.sl    = op.sl;
    param.rr    = eg_off ? 4'd0 : op.rr;
end

// output register, two clocks after the slot was addressed
always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        o_SLOT  <= 5'd0;
        o_PARAM <= '0;
    end else begin
        o_SLOT  <= slot_d1;
        o_PARAM <= param;
    end
end

endmodule

// ==== logic/opll_reg.sv ====
`timescale 1ns/1ps

module opll_reg (
    input  logic                    i_EMUCLK,
    input  logic                    i_RST_n,
    input  logic                    i_CS_n,
    input  logic                    i_WR_n,
    input  logic                    i_A0,
    input  logic [7:0]              i_D,
    output logic [4:0]              o_SLOT,
    output opll_reg_pkg::op_param_t o_PARAM
);

// write handshake
logic                  wr_req;
logic                  wr_ack;
opll_reg_pkg::reg_wr_t wr;

// slot reader read port
logic [3:0]            rd_ch;
opll_reg_pkg::chan_t   rd_chan;
opll_reg_pkg::patch_t  patch;

opll_bus_writer u_writer (
    .i_EMUCLK (i_EMUCLK),
    .i_RST_n  (i_RST_n),
    .i_CS_n   (i_CS_n),
    .i_WR_n   (i_WR_n),
    .i_A0     (i_A0),
    .i_D      (i_D),
    .i_wr_ack (wr_ack),
    .o_wr_req (wr_req),
    .o_wr     (wr)
);

opll_reg_file u_regs (
    .i_EMUCLK  (i_EMUCLK),
    .i_RST_n   (i_RST_n),
    .i_wr_req  (wr_req),
    .i_wr      (wr),
    .i_rd_ch   (rd_ch),
    .o_wr_ack  (wr_ack),
    .o_rd_chan (rd_chan),
    .o_patch   (patch)
);

opll_slot_reader u_reader (
    .i_EMUCLK  (i_EMUCLK),
    .i_RST_n   (i_RST_n),
    .i_rd_chan (rd_chan),
    .i_patch   (patch),
    .o_rd_ch   (rd_ch),
    .o_SLOT    (o_SLOT),
    .o_PARAM   (o_PARAM)
);

endmodule

// ==== testbench/tb_opll_model.svh ====
`ifndef TB_OPLL_MODEL_SVH
`define TB_OPLL_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference model of the register block
////////////////////////////////////////////////////////////////////////////

// shadow of the custom patch and the nine channels
opll_reg_pkg::patch_t m_custom;
opll_reg_pkg::chan_t  m_chan [0:8];

// built-in instruments as their eight patch register bytes, reg 0x00 on top
logic [63:0]          m_rom [1:15];

// mult byte into one operator
function automatic opll_reg_pkg::op_patch_t set_mult(
    input opll_reg_pkg::op_patch_t op,
    input logic [7:0]              d
);
    opll_reg_pkg::op_patch_t r;
    r      = op;
    r.am   = d[7];
    r.pm   = d[6];
    r.etyp = d[5];
    r.ksr  = d[4];
    r.mul  = d[3:0];
    return r;
endfunction

// one patch register byte, same rules for custom regs and rom rows
function automatic opll_reg_pkg::patch_t apply_patch_byte(
    input opll_reg_pkg::patch_t p,
    input logic [2:0]           idx,
    input logic [7:0]           d
);
    opll_reg_pkg::patch_t r;
    r = p;
    case (idx)
        3'd0: r.mod = set_mult(r.mod, d);
        3'd1: r.car = set_mult(r.car, d);
        3'd2: begin
            r.mod.ksl = d[7:6];
            r.tl      = d[5:0];
        end
        3'd3: begin
            // bit 5 unused
            r.car.ksl = d[7:6];
            r.dc      = d[4];
            r.dm      = d[3];
            r.fb      = d[2:0];
        end
        3'd4: begin
            r.mod.ar = d[7:4];
            r.mod.dr = d[3:0];
        end
        3'd5: begin
            r.car.ar = d[7:4];
            r.car.dr = d[3:0];
        end
        3'd6: begin
            r.mod.sl = d[7:4];
            r.mod.rr = d[3:0];
        end
        default: begin
            r.car.sl = d[7:4];
            r.car.rr = d[3:0];
        end
    endcase
    return r;
endfunction

// decode a rom row byte by byte
function automatic opll_reg_pkg::patch_t rom_patch(input logic [3:0] inst);
    opll_reg_pkg::patch_t p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
        p = apply_patch_byte(p, 3'(i), m_rom[inst][63 - 8*i -: 8]);
    end
    return p;
endfunction

task automatic model_reset();
    m_custom = '0;
    for (int i = 0; i < 9; i++) begin
        m_chan[i] = '0;
    end
    // violin, guitar, piano, flute, clarinet, oboe, trumpet, organ
    m_rom[1]  = 64'h7161_1E17_D078_0017;
    m_rom[2]  = 64'h1341_1A0D_D8F7_2313;
    m_rom[3]  = 64'h1301_9900_F2C4_1123;
    m_rom[4]  = 64'h3161_0E07_A864_7027;
    m_rom[5]  = 64'h3221_1E06_E076_0028;
    m_rom[6]  = 64'h3122_1605_E071_0018;
    m_rom[7]  = 64'h2161_1D07_8281_1007;
    m_rom[8]  = 64'h2321_2D14_A272_0007;
    // horn, synth, harpsichord, vibraphone, synth bass, acoustic bass, e-guitar
    m_rom[9]  = 64'h6161_1B06_6465_1017;
    m_rom[10] = 64'h4161_0B18_85F7_7107;
    m_rom[11] = 64'h1301_8311_FAE4_1004;
    m_rom[12] = 64'h17C1_2407_F8F8_2212;
    m_rom[13] = 64'h6150_0C05_C2F5_2042;
    m_rom[14] = 64'h0101_5503_C995_0302;
    m_rom[15] = 64'h6141_8903_F1E4_4013;
endtask

// register write as seen from the bus
task automatic model_write(input logic [7:0] addr, input logic [7:0] d);
    int ch;
    ch = int'(addr[3:0]);
    if (addr <= 8'h07) begin
        m_custom = apply_patch_byte(m_custom, addr[2:0], d);
    end else if (ch < 9) begin
        // 0x08-0x0f and nibbles 9-f drop out here
        case (addr[7:4])
            4'h1: m_chan[ch].fnum[7:0] = d;
            4'h2: begin
                m_chan[ch].susen   = d[5];
                m_chan[ch].kon     = d[4];
                m_chan[ch].block   = d[3:1];
                m_chan[ch].fnum[8] = d[0];
            end
            4'h3: begin
                m_chan[ch].inst = d[7:4];
                m_chan[ch].vol  = d[3:0];
            end
            default: ;
        endcase
    end
endtask

// expected output for one slot
function automatic opll_reg_pkg::op_param_t expect_param(input int slot);
    opll_reg_pkg::chan_t     c;
    opll_reg_pkg::patch_t    p;
    opll_reg_pkg::op_patch_t op;
    opll_reg_pkg::op_param_t e;
    logic                    mod;
    c   = m_chan[slot / 2];
    // even slot is the modulator
    mod = (slot % 2) == 0;
    if (c.inst == 4'h0) begin
        p = m_custom;
    end else begin
        p = rom_patch(c.inst);
    end
    op      = mod ? p.mod : p.car;
    e.fnum  = c.fnum;
    e.block = c.block;
    e.kon   = c.kon;
    e.susen = c.susen;
    e.tl    = mod ? p.tl : 6'(c.vol) * 6'd4;
    e.dc    = p.dc;
    e.dm    = p.dm;
    e.fb    = p.fb;
    e.am    = op.am;
    e.pm    = op.pm;
    e.etyp  = op.etyp;
    e.ksr   = op.ksr;
    e.mul   = op.mul;
    e.ksl   = op.ksl;
    e.ar    = op.ar;
    e.dr    = op.dr;
    e.sl    = op.sl;
    e.rr    = op.rr;
    // keyed-off modulator has no envelope movement
    if (mod && !c.kon) begin
        e.ar = 4'd0;
        e.dr = 4'd0;
        e.rr = 4'd0;
    end
    return e;
endfunction

`endif

// ==== testbench/tb_opll_reg.sv ====
`timescale 1ns/1ps

module tb_opll_reg;

// cycle cost of one bus write and one slot check
localparam int WRITE_CYC   = 26;
localparam int CHECK_CYC   = 46;
localparam int NUM_WRITES  = 186;
localparam int NUM_CHECKS  = 12;
// twice the expected run length
localparam int WATCHDOG_NS = 2 * 10 * (NUM_WRITES * WRITE_CYC + NUM_CHECKS * CHECK_CYC + 20);

logic                    i_EMUCLK;
logic                    i_RST_n;
logic                    i_CS_n;
logic                    i_WR_n;
logic                    i_A0;
logic [7:0]              i_D;
logic [4:0]              o_SLOT;
opll_reg_pkg::op_param_t o_PARAM;

integer                  seed;
int                      test_num;
int                      test_errs;
int                      total_errs;
int                      failed_tests;

`include "tb_opll_model.svh"

opll_reg uut (
    .i_EMUCLK (i_EMUCLK),
    .i_RST_n  (i_RST_n),
    .i_CS_n   (i_CS_n),
    .i_WR_n   (i_WR_n),
    .i_A0     (i_A0),
    .i_D      (i_D),
    .o_SLOT   (o_SLOT),
    .o_PARAM  (o_PARAM)
);

initial begin
    i_EMUCLK = 1'b0;
    forever #5 i_EMUCLK = ~i_EMUCLK;
end

// watchdog
initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
end

////////////////////////////////////////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////////////////////////////////////////

function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
endfunction

function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// one strobe, held 3 clocks then released 3 clocks
task automatic bus_cycle(input logic a0, input logic [7:0] val);
    @(posedge i_EMUCLK);
    i_A0   <= a0;
    i_D    <= val;
    i_CS_n <= 1'b0;
    i_WR_n <= 1'b0;
    repeat (3) @(posedge i_EMUCLK);
    i_CS_n <= 1'b1;
    i_WR_n <= 1'b1;
    repeat (3) @(posedge i_EMUCLK);
endtask

// address then data, spaced so the handshake is idle again
task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
    bus_cycle(1'b0, addr);
    bus_cycle(1'b1, data);
    repeat (12) @(posedge i_EMUCLK);
    model_write(addr, data);
endtask

// register number only
task automatic addr_only(input logic [7:0] addr);
    bus_cycle(1'b0, addr);
    repeat (12) @(posedge i_EMUCLK);
endtask

////////////////////////////////////////////////////////////////////////////
// checks and reporting
////////////////////////////////////////////////////////////////////////////

task automatic check_field(input string name, input int got, input int want);
    if (got != want) begin
        test_errs++;
        $display("** Error at %0d ns: o_PARAM.%s got 0x%0h expected 0x%0h",
                 $time, name, got, want);
    end
endtask

task automatic compare_param(
    input opll_reg_pkg::op_param_t got,
    input opll_reg_pkg::op_param_t want
);
    check_field("fnum", 32'(got.fnum), 32'(want.fnum));
    check_field("block", 32'(got.block), 32'(want.block));
    check_field("kon", 32'(got.kon), 32'(want.kon));
    check_field("susen", 32'(got.susen), 32'(want.susen));
    check_field("tl", 32'(got.tl), 32'(want.tl));
    check_field("dc", 32'(got.dc), 32'(want.dc));
    check_field("dm", 32'(got.dm), 32'(want.dm));
    check_field("fb", 32'(got.fb), 32'(want.fb));
    check_field("am", 32'(got.am), 32'(want.am));
    check_field("pm", 32'(got.pm), 32'(want.pm));
    check_field("etyp", 32'(got.etyp), 32'(want.etyp));
    check_field("ksr", 32'(got.ksr), 32'(want.ksr));
    check_field("mul", 32'(got.mul), 32'(want.mul));
    check_field("ksl", 32'(got.ksl), 32'(want.ksl));
    check_field("ar", 32'(got.ar), 32'(want.ar));
    check_field("dr", 32'(got.dr), 32'(want.dr));
    check_field("sl", 32'(got.sl), 32'(want.sl));
    check_field("rr", 32'(got.rr), 32'(want.rr));
endtask

// two full scans, sampled on the falling edge
task automatic check_slots();
    opll_reg_pkg::op_param_t want;
    int                      slot;
    int                      prev;
    repeat (8) @(posedge i_EMUCLK);
    prev = -1;
    for (int i = 0; i < 36; i++) begin
        @(negedge i_EMUCLK);
        slot = int'(o_SLOT);
        if (prev >= 0 && slot != (prev + 1) % 18) begin
            test_errs++;
            $display("** Error at %0d ns: o_SLOT got %0d expected %0d",
                     $time, slot, (prev + 1) % 18);
        end
        if (slot >= 18) begin
            test_errs++;
            $display("Slot number %0d at %0d ns is outside the 18-slot scan", slot, $time);
        end else begin
            want = expect_param(slot);
            compare_param(o_PARAM, want);
        end
        prev = slot;
    end
endtask

task automatic end_test(input string name);
    test_num++;
    if (test_errs == 0) begin
        $display("test %0d %s: ok", test_num, name);
    end else begin
        $display("test %0d %s: %0d errors", test_num, name, test_errs);
        failed_tests++;
    end
    total_errs += test_errs;
    test_errs  = 0;
endtask

////////////////////////////////////////////////////////////////////////////
// test sequence
////////////////////////////////////////////////////////////////////////////

initial begin
    int ch;
    int r;
    seed         = 32'hfa9a_d03e;
    test_num     = 0;
    test_errs    = 0;
    total_errs   = 0;
    failed_tests = 0;
    i_RST_n      = 1'b0;
    i_CS_n       = 1'b1;
    i_WR_n       = 1'b1;
    i_A0         = 1'b0;
    i_D          = 8'h00;
    model_reset();
    repeat (2) @(posedge i_EMUCLK);
    i_RST_n <= 1'b1;

    // all slots quiet out of reset
    check_slots();
    end_test("reset state");

    // pitch, block and key bits on random channels
    repeat (2) begin
        repeat (18) begin
            ch = rand_below(9);
            if (rand_below(2) == 0) begin
                bus_write(opll_reg_pkg::ADDR_FNUM_LO | 8'(ch), rand_byte());
            end else begin
                bus_write(opll_reg_pkg::ADDR_FNUM_HI | 8'(ch), rand_byte());
            end
        end
        check_slots();
    end
    end_test("fnum and key-on");

    // key on everywhere so modulator rates stay visible
    for (int c = 0; c < 9; c++) begin
        bus_write(opll_reg_pkg::ADDR_FNUM_HI | 8'(c), 8'h10 | (rand_byte() & 8'h2F));
    end
    repeat (3) begin
        for (int c = 0; c < 9; c++) begin
            r = 1 + rand_below(15);
            bus_write(opll_reg_pkg::ADDR_INST_VOL | 8'(c), {4'(r), 4'(rand_below(16))});
        end
        check_slots();
    end
    end_test("rom instruments");

    // custom patch through instrument 0
    repeat (2) begin
        for (int c = 0; c < 9; c++) begin
            bus_write(opll_reg_pkg::ADDR_INST_VOL | 8'(c), {4'h0, 4'(rand_below(16))});
        end
        for (int a = 0; a < 8; a++) begin
            bus_write(8'(a), rand_byte());
        end
        check_slots();
    end
    end_test("custom patch");

    // random key-on, volume and instrument mix
    repeat (3) begin
        for (int c = 0; c < 9; c++) begin
            bus_write(opll_reg_pkg::ADDR_FNUM_HI | 8'(c), rand_byte());
            bus_write(opll_reg_pkg::ADDR_INST_VOL | 8'(c), rand_byte());
        end
        check_slots();
    end
    end_test("total level and key-off rates");

    // holes in the map and bare address cycles
    for (int a = 8'h08; a <= 8'h0F; a++) begin
        bus_write(8'(a), rand_byte());
    end
    for (int a = 8'h19; a <= 8'h1F; a++) begin
        bus_write(8'(a), rand_byte());
    end
    for (int a = 8'h39; a <= 8'h3F; a++) begin
        bus_write(8'(a), rand_byte());
    end
    repeat (4) begin
        addr_only(rand_byte());
    end
    check_slots();
    end_test("unmapped writes");

    $display("tests %0d, failed %0d, errors %0d", test_num, failed_tests, total_errs);
    if (total_errs == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// ==== sources.f ====
+incdir+testbench
logic/opll_reg_pkg.sv
logic/opll_patch_rom.sv
logic/opll_bus_writer.sv
logic/opll_reg_file.sv
logic/opll_slot_reader.sv
logic/opll_reg.sv
testbench/tb_opll_reg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_opll_reg

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module "$TOP" \
    --Mdir obj_dir \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "run_sim: compile failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi
